// File: files.f
rtl/trs_io_pkg.sv
rtl/esp_spi_slave.sv
rtl/cmd_parser.sv
rtl/cmd_regs.sv
rtl/flash_spi_master.sv
rtl/z80_io_decoder.sv
rtl/trs_io_top.sv
dv/tb_trs_io_top.sv

// File: Bender.yml
package:
  name: trs_io

sources:
  - rtl/trs_io_pkg.sv
  - rtl/esp_spi_slave.sv
  - rtl/cmd_parser.sv
  - rtl/cmd_regs.sv
  - rtl/flash_spi_master.sv
  - rtl/z80_io_decoder.sv
  - rtl/trs_io_top.sv
  - target: test
    files:
      - dv/tb_trs_io_top.sv

// File: dv/tb_trs_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_trs_io_top;
  import trs_io_pkg::*;

  localparam int MAX_ROWS = 24;
  localparam int SPI_HALF = 8;
  localparam int K_SPI    = 0;
  localparam int K_Z80    = 1;
  localparam int C_NONE   = 0;
  localparam int C_RESP   = 1;
  localparam int C_LED    = 2;
  localparam int C_ERR    = 3;
  localparam int C_CSN    = 4;
  localparam int C_INT    = 5;
  localparam int C_RDATA  = 6;
  localparam logic S_IN   = 1'b0;
  localparam logic S_OUT  = 1'b1;
  // eight bits, sck high for half of each 16-clk bit
  localparam int SCK_HIGH_XFER = 64;

  logic      clk = 1'b0;
  logic      cass_out_sel_n;
  logic      spi_cs_n;
  logic      spi_sck;
  logic      spi_mosi;
  logic      spi_miso;
  byte_t     io_addr;
  byte_t     io_wdata;
  logic      io_in_n;
  logic      io_out_n;
  byte_t     io_rdata;
  logic      wait_n;
  logic      int_n;
  logic      esp_req;
  esp_code_t esp_s;
  logic      esp_done;
  conf_t     conf;
  led_t      led_rgb;
  logic      err_led;
  logic      flash_cs_n;
  logic      flash_sck;
  logic      flash_si;
  logic      flash_so;

  // stimulus and expected values, one row per test
  string     t_name [MAX_ROWS];
  int        t_kind [MAX_ROWS];
  byte_t     t_op   [MAX_ROWS];
  byte_t     t_prm  [MAX_ROWS];
  byte_t     t_addr [MAX_ROWS];
  logic      t_strb [MAX_ROWS];
  conf_t     t_conf [MAX_ROWS];
  esp_code_t t_esp  [MAX_ROWS];
  int        t_chk  [MAX_ROWS];
  byte_t     t_exp  [MAX_ROWS];
  int        n_rows = 0;

  int    err_cnt     = 0;
  int    pass_cnt    = 0;
  int    fail_cnt    = 0;
  int    cycles      = 0;
  int    cycle_limit = 0;
  int    sck_highs   = 0;
  byte_t rnd_led;
  byte_t rnd_db;
  byte_t rnd_f1;
  byte_t rnd_f2;

  // flash loopback, a transfer returns the byte sent
  assign flash_so = flash_si;

  trs_io_top trs_io_top_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .spi_cs_n(spi_cs_n), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
    .io_addr(io_addr), .io_wdata(io_wdata), .io_in_n(io_in_n), .io_out_n(io_out_n),
    .io_rdata(io_rdata), .wait_n(wait_n), .int_n(int_n), .esp_req(esp_req),
    .esp_s(esp_s), .esp_done(esp_done), .conf(conf), .led_rgb(led_rgb),
    .err_led(err_led), .flash_cs_n(flash_cs_n), .flash_sck(flash_sck),
    .flash_si(flash_si), .flash_so(flash_so)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  // clk cycles with flash_sck high
  always @(posedge clk) begin
    if (flash_sck) begin
      sck_highs <= sck_highs + 1;
    end
  end

  task automatic add_row(input string name, input int kind, input byte_t op,
                         input byte_t prm, input byte_t addr, input logic strb,
                         input conf_t cfg, input esp_code_t esp, input int chk,
                         input byte_t exp);
    t_name[n_rows] = name;
    t_kind[n_rows] = kind;
    t_op[n_rows]   = op;
    t_prm[n_rows]  = prm;
    t_addr[n_rows] = addr;
    t_strb[n_rows] = strb;
    t_conf[n_rows] = cfg;
    t_esp[n_rows]  = esp;
    t_chk[n_rows]  = chk;
    t_exp[n_rows]  = exp;
    n_rows++;
  endtask

  task automatic build_table();
    add_row("get_cookie", K_SPI, get_cookie, 0, 0, S_IN, 4'h8, esp_none, C_RESP, COOKIE);
    add_row("get_version", K_SPI, get_version, 0, 0, S_IN, 4'h8, esp_none, C_RESP,
            {VERSION_MAJOR, VERSION_MINOR});
    add_row("set_led", K_SPI, set_led, rnd_led, 0, S_IN, 4'h8, esp_none, C_LED,
            {5'd0, rnd_led[2:0]});
    add_row("get_config", K_SPI, get_config, 0, 0, S_IN, 4'h5, esp_none, C_RESP,
            {4'h0, ~4'h5});
    add_row("unknown_opcode", K_SPI, 8'h77, 0, 0, S_IN, 4'h8, esp_none, C_ERR, 8'h01);
    add_row("dbus_write", K_SPI, dbus_write, rnd_db, 0, S_IN, 4'h8, esp_none, C_INT, 8'h01);
    add_row("data_ready", K_SPI, data_ready, 0, 0, S_IN, 4'h8, esp_none, C_INT, 8'h00);
    add_row("trs_io_in", K_Z80, 0, 0, 8'h1F, S_IN, 4'h8, esp_trs_io_in, C_RDATA, rnd_db);
    add_row("trs_io_out", K_Z80, 0, 8'h5A, 8'h1F, S_OUT, 4'h8, esp_trs_io_out, C_NONE, 0);
    add_row("frehd_in", K_Z80, 0, 0, 8'hC5, S_IN, 4'h8, esp_frehd_in, C_RDATA, rnd_db);
    add_row("printer_wr", K_Z80, 0, 8'h41, 8'hFA, S_OUT, 4'h8, esp_printer_wr, C_NONE, 0);
    add_row("vprinter_off", K_SPI, set_vprinter_en, 8'h00, 0, S_IN, 4'h8, esp_none,
            C_NONE, 0);
    add_row("printer_disabled", K_Z80, 0, 0, 8'hFA, S_IN, 4'h8, esp_none, C_RDATA, 8'hFF);
    add_row("trs_io_conf_clear", K_Z80, 0, 0, 8'h1F, S_IN, 4'h0, esp_none, C_RDATA, 8'hFF);
    add_row("plain_port_read", K_Z80, 0, 0, 8'h40, S_IN, 4'h8, esp_none, C_RDATA, 8'hFF);
    add_row("flash_select", K_SPI, set_spi_ctrl_reg, 8'h80, 0, S_IN, 4'h8, esp_none,
            C_CSN, 8'h00);
    add_row("flash_cmd_write", K_SPI, set_spi_data, rnd_f1, 0, S_IN, 4'h8, esp_none,
            C_NONE, 0);
    add_row("flash_cmd_read", K_SPI, get_spi_data, 0, 0, S_IN, 4'h8, esp_none, C_RESP,
            rnd_f1);
    add_row("flash_z80_write", K_Z80, 0, rnd_f2, 8'hFD, S_OUT, 4'h8, esp_none, C_NONE, 0);
    add_row("flash_z80_read", K_Z80, 0, 0, 8'hFD, S_IN, 4'h8, esp_none, C_RDATA, rnd_f2);
  endtask

  // longest a row of each kind can take, bounded waits included
  function automatic int row_budget(input int kind);
    if (kind == K_SPI) begin
      return 3 * 16 * SPI_HALF + 440;
    end
    return 2 * ESP_REQ_CYCLES + 480;
  endfunction

  function automatic logic takes_param(input byte_t op);
    case (op)
      byte_t'(dbus_write), byte_t'(set_led), byte_t'(set_spi_ctrl_reg),
      byte_t'(set_spi_data), byte_t'(set_vprinter_en): return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // rows that write the flash data register
  function automatic logic starts_transfer(input int r);
    if (t_kind[r] == K_SPI) begin
      return t_op[r] == byte_t'(set_spi_data);
    end
    return t_addr[r] == 8'hFD && t_strb[r] == S_OUT;
  endfunction

  task automatic check_byte(input string name, input string what, input byte_t exp,
                            input byte_t act);
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected %02h, actual %02h", name, what, exp, act);
      err_cnt++;
    end
  endtask

  // mode 0, MSB first, MISO read just before the rising edge
  task automatic spi_byte(input byte_t tx, output byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      spi_mosi = tx[i];
      repeat (SPI_HALF) @(negedge clk);
      rx[i] = spi_miso;
      spi_sck = 1'b1;
      repeat (SPI_HALF) @(negedge clk);
      spi_sck = 1'b0;
    end
  endtask

  task automatic wait_flash_idle(input string name);
    int n;
    int low_cnt;
    n = 0;
    low_cnt = 0;
    while (low_cnt < 20 && n < 400) begin
      @(negedge clk);
      n++;
      low_cnt = flash_sck ? 0 : low_cnt + 1;
    end
    assert (low_cnt >= 20) else begin
      $display("test %s: flash transfer never went idle", name);
      err_cnt++;
    end
  endtask

  task automatic spi_command(input int r);
    byte_t rx;
    spi_cs_n = 1'b0;
    repeat (4) @(negedge clk);
    spi_byte(t_op[r], rx);
    if (takes_param(t_op[r])) begin
      spi_byte(t_prm[r], rx);
    end
    // a harmless get_cookie clocks the response out
    if (t_chk[r] == C_RESP) begin
      spi_byte(byte_t'(get_cookie), rx);
    end
    spi_cs_n = 1'b1;
    repeat (4) @(negedge clk);
    wait_flash_idle(t_name[r]);
    case (t_chk[r])
      C_RESP: check_byte(t_name[r], "response", t_exp[r], rx);
      C_LED:  check_byte(t_name[r], "led_rgb", t_exp[r], {5'd0, led_rgb});
      C_ERR:  check_byte(t_name[r], "err_led", t_exp[r], {7'd0, err_led});
      C_CSN:  check_byte(t_name[r], "flash_cs_n", t_exp[r], {7'd0, flash_cs_n});
      C_INT:  check_byte(t_name[r], "int_n", t_exp[r], {7'd0, int_n});
      default: ;
    endcase
  endtask

  task automatic z80_access(input int r);
    int n;
    int req_len;
    io_addr  = t_addr[r];
    io_wdata = t_prm[r];
    if (t_strb[r] == S_IN) begin
      io_in_n = 1'b0;
    end else begin
      io_out_n = 1'b0;
    end
    @(negedge clk);
    check_byte(t_name[r], "esp_s", {4'h0, t_esp[r]}, {4'h0, esp_s});
    if (t_esp[r] != esp_none) begin
      n = 0;
      while (!esp_req && n < 20) begin
        @(negedge clk);
        n++;
      end
      assert (esp_req) else begin
        $display("test %s: esp_req never rose", t_name[r]);
        err_cnt++;
      end
      check_byte(t_name[r], "wait_n", 8'h00, {7'd0, wait_n});
      req_len = 0;
      while (esp_req && req_len < 2 * ESP_REQ_CYCLES) begin
        @(negedge clk);
        req_len++;
      end
      check_byte(t_name[r], "esp_req cycles", byte_t'(ESP_REQ_CYCLES), byte_t'(req_len));
      // Z80 must still be held until the ESP answers
      check_byte(t_name[r], "wait_n before done", 8'h00, {7'd0, wait_n});
      esp_done = 1'b1;
      n = 0;
      while (!wait_n && n < 20) begin
        @(negedge clk);
        n++;
      end
      esp_done = 1'b0;
      assert (wait_n) else begin
        $display("test %s: wait_n stayed low after esp_done", t_name[r]);
        err_cnt++;
      end
    end else begin
      repeat (6) @(negedge clk);
    end
    if (t_chk[r] == C_RDATA) begin
      check_byte(t_name[r], "io_rdata", t_exp[r], io_rdata);
    end
    io_in_n  = 1'b1;
    io_out_n = 1'b1;
    repeat (4) @(negedge clk);
    if (t_addr[r] == 8'h1F && t_esp[r] != esp_none) begin
      check_byte(t_name[r], "int_n after access", 8'h01, {7'd0, int_n});
    end
    wait_flash_idle(t_name[r]);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("%-20s ok", name);
      pass_cnt++;
    end else begin
      $display("%-20s FAILED", name);
      fail_cnt++;
    end
  endtask

  initial begin
    int errs_before;
    int budget;
    int sck_before;
    int sck_exp;
    cass_out_sel_n = 1'b0;
    spi_cs_n       = 1'b1;
    spi_sck        = 1'b0;
    spi_mosi       = 1'b0;
    io_addr        = 8'h00;
    io_wdata       = 8'h00;
    io_in_n        = 1'b1;
    io_out_n       = 1'b1;
    esp_done       = 1'b0;
    conf           = 4'h8;
    void'($urandom(15));
    rnd_led = byte_t'($urandom());
    rnd_db  = byte_t'($urandom());
    rnd_f1  = byte_t'($urandom());
    rnd_f2  = byte_t'($urandom());
    build_table();
    budget = 200;
    for (int r = 0; r < n_rows; r++) begin
      budget += row_budget(t_kind[r]);
    end
    cycle_limit = budget + 1000;

    repeat (5) @(negedge clk);
    cass_out_sel_n = 1'b1;
    repeat (2) @(negedge clk);

    errs_before = err_cnt;
    check_byte("reset_values", "esp_req", 8'h00, {7'd0, esp_req});
    check_byte("reset_values", "wait_n", 8'h01, {7'd0, wait_n});
    check_byte("reset_values", "int_n", 8'h01, {7'd0, int_n});
    check_byte("reset_values", "flash_cs_n", 8'h01, {7'd0, flash_cs_n});
    check_byte("reset_values", "flash_sck", 8'h00, {7'd0, flash_sck});
    check_byte("reset_values", "err_led", 8'h00, {7'd0, err_led});
    check_byte("reset_values", "led_rgb", 8'h00, {5'd0, led_rgb});
    report_test("reset_values", errs_before);

    for (int r = 0; r < n_rows; r++) begin
      errs_before = err_cnt;
      sck_before  = sck_highs;
      conf = t_conf[r];
      @(negedge clk);
      if (t_kind[r] == K_SPI) begin
        spi_command(r);
      end else begin
        z80_access(r);
      end
      sck_exp = starts_transfer(r) ? SCK_HIGH_XFER : 0;
      assert (sck_highs - sck_before == sck_exp) else begin
        $display("[ERROR] %s flash_sck high cycles: expected %0d, actual %0d",
                 t_name[r], sck_exp, sck_highs - sck_before);
        err_cnt++;
      end
      report_test(t_name[r], errs_before);
    end

    $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/trs_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module trs_io_top (
  input  logic                  clk,
  input  logic                  cass_out_sel_n,
  input  logic                  spi_cs_n,
  input  logic                  spi_sck,
  input  logic                  spi_mosi,
  output logic                  spi_miso,
  input  trs_io_pkg::byte_t     io_addr,
  input  trs_io_pkg::byte_t     io_wdata,
  input  logic                  io_in_n,
  input  logic                  io_out_n,
  output trs_io_pkg::byte_t     io_rdata,
  output logic                  wait_n,
  output logic                  int_n,
  output logic                  esp_req,
  output trs_io_pkg::esp_code_t esp_s,
  input  logic                  esp_done,
  input  trs_io_pkg::conf_t     conf,
  output trs_io_pkg::led_t      led_rgb,
  output logic                  err_led,
  output logic                  flash_cs_n,
  output logic                  flash_sck,
  output logic                  flash_si,
  input  logic                  flash_so
);
  import trs_io_pkg::*;

  byte_t rx_byte;
  logic  rx_valid;
  logic  cmd_fire;
  cmd_t  cmd;
  byte_t param;
  logic  bad_cmd;
  byte_t resp_byte;
  logic  vprinter_en;
  byte_t esp_data;
  logic  data_ready_set;
  logic  cmd_ctrl_we;
  logic  cmd_data_we;
  logic  z80_ctrl_we;
  logic  z80_data_we;
  byte_t z80_wdata;
  byte_t flash_rdata;

  esp_spi_slave #(
    .SYNC_STAGES(SYNC_STAGES)
  ) esp_spi_slave_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .spi_cs_n(spi_cs_n), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
    .resp_byte(resp_byte), .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  cmd_parser cmd_parser_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .rx_byte(rx_byte), .rx_valid(rx_valid),
    .cmd_fire(cmd_fire), .cmd(cmd), .param(param), .bad_cmd(bad_cmd)
  );

  cmd_regs cmd_regs_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .cmd_fire(cmd_fire), .cmd(cmd), .param(param), .bad_cmd(bad_cmd),
    .conf(conf), .flash_rdata(flash_rdata),
    .resp_byte(resp_byte), .led_rgb(led_rgb), .err_led(err_led),
    .vprinter_en(vprinter_en), .esp_data(esp_data), .data_ready_set(data_ready_set),
    .cmd_ctrl_we(cmd_ctrl_we), .cmd_data_we(cmd_data_we)
  );

  flash_spi_master flash_spi_master_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .cmd_ctrl_we(cmd_ctrl_we), .cmd_data_we(cmd_data_we), .param(param),
    .z80_ctrl_we(z80_ctrl_we), .z80_data_we(z80_data_we), .z80_wdata(z80_wdata),
    .flash_so(flash_so), .flash_cs_n(flash_cs_n), .flash_sck(flash_sck),
    .flash_si(flash_si), .flash_rdata(flash_rdata)
  );

  z80_io_decoder #(
    .SYNC_STAGES(SYNC_STAGES)
  ) z80_io_decoder_inst (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .io_addr(io_addr), .io_wdata(io_wdata), .io_in_n(io_in_n), .io_out_n(io_out_n),
    .conf(conf), .vprinter_en(vprinter_en), .esp_data(esp_data),
    .data_ready_set(data_ready_set), .esp_done(esp_done), .flash_rdata(flash_rdata),
    .io_rdata(io_rdata), .wait_n(wait_n), .int_n(int_n), .esp_req(esp_req),
    .esp_s(esp_s), .z80_ctrl_we(z80_ctrl_we), .z80_data_we(z80_data_we),
    .z80_wdata(z80_wdata)
  );

endmodule

`default_nettype wire

// File: rtl/z80_io_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module z80_io_decoder #(
  parameter int SYNC_STAGES = trs_io_pkg::SYNC_STAGES
) (
  input  logic                  clk,
  input  logic                  cass_out_sel_n,
  input  trs_io_pkg::byte_t     io_addr,
  input  trs_io_pkg::byte_t     io_wdata,
  input  logic                  io_in_n,
  input  logic                  io_out_n,
  input  trs_io_pkg::conf_t     conf,
  input  logic                  vprinter_en,
  input  trs_io_pkg::byte_t     esp_data,
  input  logic                  data_ready_set,
  input  logic                  esp_done,
  input  trs_io_pkg::byte_t     flash_rdata,
  output trs_io_pkg::byte_t     io_rdata,
  output logic                  wait_n,
  output logic                  int_n,
  output logic                  esp_req,
  output trs_io_pkg::esp_code_t esp_s,
  output logic                  z80_ctrl_we,
  output logic                  z80_data_we,
  output trs_io_pkg::byte_t     z80_wdata
);
  import trs_io_pkg::*;

  logic [SYNC_STAGES:0] in_q;
  logic [SYNC_STAGES:0] out_q;
  logic [SYNC_STAGES:0] done_q;
  logic                 in_fall;
  logic                 out_fall;
  logic                 done_rise;
  logic                 access_start;
  logic                 trs_sel;
  logic                 frehd_sel;
  logic                 prn_sel;
  logic                 esp_sel;
  logic                 esp_rd;
  logic [ESP_REQ_W-1:0] req_cnt;
  logic                 wait_q;
  logic                 int_q;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      in_q   <= '1;
      out_q  <= '1;
      done_q <= '0;
    end else begin
      in_q   <= (SYNC_STAGES+1)'({in_q, io_in_n});
      out_q  <= (SYNC_STAGES+1)'({out_q, io_out_n});
      done_q <= (SYNC_STAGES+1)'({done_q, esp_done});
    end
  end

  assign in_fall      = ~in_q[SYNC_STAGES-1] & in_q[SYNC_STAGES];
  assign out_fall     = ~out_q[SYNC_STAGES-1] & out_q[SYNC_STAGES];
  assign done_rise    = done_q[SYNC_STAGES-1] & ~done_q[SYNC_STAGES];
  assign access_start = in_fall | out_fall;

  // trs-io and FreHD only with conf[3] set
  assign trs_sel   = conf[3] && (io_addr == PORT_TRS_IO);
  assign frehd_sel = conf[3] && (io_addr[7:4] == PORT_FREHD_HI);
  assign prn_sel   = vprinter_en && (io_addr[7:2] == PORT_PRINTER_HI6);

  always_comb begin
    esp_s = esp_none;
    if (!io_in_n) begin
      if (trs_sel)        esp_s = esp_trs_io_in;
      else if (frehd_sel) esp_s = esp_frehd_in;
      else if (prn_sel)   esp_s = esp_printer_rd;
    end else if (!io_out_n) begin
      if (trs_sel)        esp_s = esp_trs_io_out;
      else if (frehd_sel) esp_s = esp_frehd_out;
      else if (prn_sel)   esp_s = esp_printer_wr;
    end
  end

  assign esp_sel = (esp_s != esp_none);
  assign esp_rd  = (esp_s == esp_trs_io_in) || (esp_s == esp_frehd_in) ||
                   (esp_s == esp_printer_rd);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      req_cnt <= '0;
      wait_q  <= 1'b0;
      int_q   <= 1'b0;
    end else begin
      if (access_start && esp_sel) begin
        req_cnt <= ESP_REQ_W'(ESP_REQ_CYCLES);
        wait_q  <= 1'b1;
      end else begin
        if (req_cnt != '0) begin
          req_cnt <= req_cnt - 1'b1;
        end
        // Z80 resumes once the ESP signals completion
        if (done_rise) begin
          wait_q <= 1'b0;
        end
      end
      if (access_start && trs_sel) begin
        int_q <= 1'b0;
      end else if (data_ready_set) begin
        int_q <= 1'b1;
      end
    end
  end

  assign esp_req = (req_cnt != '0);
  assign wait_n  = ~wait_q;
  assign int_n   = ~int_q;

  assign z80_ctrl_we = out_fall && (io_addr == PORT_FLASH_CTRL);
  assign z80_data_we = out_fall && (io_addr == PORT_FLASH_DATA);
  assign z80_wdata   = io_wdata;

  always_comb begin
    if (esp_rd) begin
      io_rdata = esp_data;
    end else if (!io_in_n && io_addr == PORT_FLASH_DATA) begin
      io_rdata = flash_rdata;
    end else begin
      io_rdata = 8'hFF;
    end
  end

endmodule

`default_nettype wire

// File: rtl/flash_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module flash_spi_master (
  input  logic              clk,
  input  logic              cass_out_sel_n,
  input  logic              cmd_ctrl_we,
  input  logic              cmd_data_we,
  input  trs_io_pkg::byte_t param,
  input  logic              z80_ctrl_we,
  input  logic              z80_data_we,
  input  trs_io_pkg::byte_t z80_wdata,
  input  logic              flash_so,
  output logic              flash_cs_n,
  output logic              flash_sck,
  output logic              flash_si,
  output trs_io_pkg::byte_t flash_rdata
);
  import trs_io_pkg::*;

  // bit 7 selects the flash
  byte_t                        ctrl_reg;
  byte_t                        shift_reg;
  logic                         busy;
  // upper three bits count the bit, the rest the phase within it
  logic [FLASH_PHASE_W+2:0]     cnt;
  logic [FLASH_PHASE_W-1:0]     phase;
  logic                         start;

  assign phase = cnt[FLASH_PHASE_W-1:0];
  assign start = !busy && (z80_data_we || cmd_data_we);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      ctrl_reg <= '0;
      busy     <= 1'b0;
      cnt      <= '0;
      flash_si <= 1'b0;
    end else begin
      if (z80_ctrl_we) begin
        ctrl_reg <= z80_wdata;
      end else if (cmd_ctrl_we) begin
        ctrl_reg <= param;
      end
      if (start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (phase == '0) begin
          flash_si <= shift_reg[7];
        end
        if (&cnt) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      shift_reg <= z80_data_we ? z80_wdata : param;
    end else if (busy && phase == FLASH_PHASE_W'(FLASH_BIT_CYCLES / 2)) begin
      shift_reg <= {shift_reg[6:0], flash_so};
    end
  end

  assign flash_cs_n  = ~ctrl_reg[7];
  assign flash_sck   = busy & cnt[FLASH_PHASE_W-1];
  assign flash_rdata = shift_reg;

endmodule

`default_nettype wire

// File: rtl/cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_regs (
  input  logic              clk,
  input  logic              cass_out_sel_n,
  input  logic              cmd_fire,
  input  trs_io_pkg::cmd_t  cmd,
  input  trs_io_pkg::byte_t param,
  input  logic              bad_cmd,
  input  trs_io_pkg::conf_t conf,
  input  trs_io_pkg::byte_t flash_rdata,
  output trs_io_pkg::byte_t resp_byte,
  output trs_io_pkg::led_t  led_rgb,
  output logic              err_led,
  output logic              vprinter_en,
  output trs_io_pkg::byte_t esp_data,
  output logic              data_ready_set,
  output logic              cmd_ctrl_we,
  output logic              cmd_data_we
);
  import trs_io_pkg::*;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      resp_byte   <= '0;
      led_rgb     <= '0;
      err_led     <= 1'b0;
      vprinter_en <= 1'b1;
    end else begin
      // error stays lit until the next reset
      if (bad_cmd) begin
        err_led <= 1'b1;
      end
      if (cmd_fire) begin
        case (cmd)
          get_cookie:      resp_byte <= COOKIE;
          get_version:     resp_byte <= {VERSION_MAJOR, VERSION_MINOR};
          get_config:      resp_byte <= {4'h0, ~conf};
          get_spi_data:    resp_byte <= flash_rdata;
          set_led:         led_rgb <= param[2:0];
          set_vprinter_en: vprinter_en <= param[0];
          default: ;
        endcase
      end
    end
  end

  // byte the Z80 reads back from the ESP ports
  always_ff @(posedge clk) begin
    if (cmd_fire && cmd == dbus_write) begin
      esp_data <= param;
    end
  end

  assign data_ready_set = cmd_fire && (cmd == data_ready);
  assign cmd_ctrl_we    = cmd_fire && (cmd == set_spi_ctrl_reg);
  assign cmd_data_we    = cmd_fire && (cmd == set_spi_data);

endmodule

`default_nettype wire

// File: rtl/cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
  input  logic              clk,
  input  logic              cass_out_sel_n,
  input  trs_io_pkg::byte_t rx_byte,
  input  logic              rx_valid,
  output logic              cmd_fire,
  output trs_io_pkg::cmd_t  cmd,
  output trs_io_pkg::byte_t param,
  output logic              bad_cmd
);
  import trs_io_pkg::*;

  parser_state_t state;
  logic          known;
  logic          needs_param;

  // opcode classification
  always_comb begin
    known       = 1'b1;
    needs_param = 1'b0;
    case (rx_byte)
      get_cookie, get_version, get_config, get_spi_data, data_ready: begin
        needs_param = 1'b0;
      end
      dbus_write, set_led, set_spi_ctrl_reg, set_spi_data, set_vprinter_en: begin
        needs_param = 1'b1;
      end
      default: begin
        known = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state    <= idle;
      cmd_fire <= 1'b0;
      bad_cmd  <= 1'b0;
    end else begin
      cmd_fire <= 1'b0;
      bad_cmd  <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            if (!known) begin
              bad_cmd <= 1'b1;
            end else if (needs_param) begin
              state <= read_param;
            end else begin
              cmd_fire <= 1'b1;
            end
          end
          read_param: begin
            cmd_fire <= 1'b1;
            state    <= idle;
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // opcode and parameter capture
  always_ff @(posedge clk) begin
    if (rx_valid && state == idle && known) begin
      cmd <= cmd_t'(rx_byte);
    end
    if (rx_valid && state == read_param) begin
      param <= rx_byte;
    end
  end

endmodule

`default_nettype wire

// File: rtl/esp_spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module esp_spi_slave #(
  parameter int SYNC_STAGES = trs_io_pkg::SYNC_STAGES
) (
  input  logic              clk,
  input  logic              cass_out_sel_n,
  input  logic              spi_cs_n,
  input  logic              spi_sck,
  input  logic              spi_mosi,
  output logic              spi_miso,
  input  trs_io_pkg::byte_t resp_byte,
  output trs_io_pkg::byte_t rx_byte,
  output logic              rx_valid
);
  import trs_io_pkg::*;

  // sck needs one stage more than the others for edge detection
  logic [SYNC_STAGES:0]   sck_q;
  logic [SYNC_STAGES-1:0] cs_q;
  logic [SYNC_STAGES-1:0] mosi_q;
  logic                   cs_active;
  logic                   sck_rise;
  logic                   sck_fall;
  logic [2:0]             bit_cnt;
  byte_t                  tx_shift;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_q  <= '0;
      cs_q   <= '1;
      mosi_q <= '0;
    end else begin
      sck_q  <= (SYNC_STAGES+1)'({sck_q, spi_sck});
      cs_q   <= SYNC_STAGES'({cs_q, spi_cs_n});
      mosi_q <= SYNC_STAGES'({mosi_q, spi_mosi});
    end
  end

  assign cs_active = ~cs_q[SYNC_STAGES-1];
  assign sck_rise  = sck_q[SYNC_STAGES-1] & ~sck_q[SYNC_STAGES];
  assign sck_fall  = ~sck_q[SYNC_STAGES-1] & sck_q[SYNC_STAGES];

  // bit count restarts whenever the ESP drops CS
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        rx_valid <= (bit_cnt == 3'd7);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_q[SYNC_STAGES-1]};
    end
    // response is reloaded until the first bit of a byte is clocked
    if (cs_active && bit_cnt == 3'd0) begin
      tx_shift <= resp_byte;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign spi_miso = cs_active ? tx_shift[7] : 1'bz;

endmodule

`default_nettype wire

// File: rtl/trs_io_pkg.sv
`default_nettype none

package trs_io_pkg;

  // data, address and command bytes on both buses
  typedef logic [7:0] byte_t;
  // dip switches, read back inverted by get_config
  typedef logic [3:0] conf_t;
  // red, green, blue
  typedef logic [2:0] led_t;

  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    dbus_write       = 8'd4,
    data_ready       = 8'd5,
    get_version      = 8'd15,
    set_led          = 8'd26,
    get_config       = 8'd27,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31,
    set_vprinter_en  = 8'd33
  } cmd_t;

  // select code shown to the ESP during a request
  typedef enum logic [3:0] {
    esp_trs_io_in  = 4'd0,
    esp_trs_io_out = 4'd1,
    esp_frehd_in   = 4'd2,
    esp_frehd_out  = 4'd3,
    esp_printer_rd = 4'd4,
    esp_printer_wr = 4'd5,
    esp_none       = 4'd15
  } esp_code_t;

  typedef enum logic {
    idle,
    read_param
  } parser_state_t;

  localparam byte_t      COOKIE        = 8'hAF;
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  localparam byte_t      PORT_TRS_IO      = 8'h1F;
  localparam logic [3:0] PORT_FREHD_HI    = 4'hC;
  // F8h..FBh
  localparam logic [5:0] PORT_PRINTER_HI6 = 6'b111110;
  localparam byte_t      PORT_FLASH_CTRL  = 8'hFC;
  localparam byte_t      PORT_FLASH_DATA  = 8'hFD;

  localparam int ESP_REQ_CYCLES   = 50;
  localparam int ESP_REQ_W        = $clog2(ESP_REQ_CYCLES + 1);
  localparam int FLASH_BIT_CYCLES = 16;
  localparam int FLASH_PHASE_W    = $clog2(FLASH_BIT_CYCLES);
  localparam int SYNC_STAGES      = 2;

endpackage

`default_nettype wire
